/* bus_interconnect.f */
bus_pkg.sv
arb_pkg.sv
slave_regbank.sv
bus_arbiter.sv
addr_decoder.sv
bus_transfer.sv
bus_interconnect.sv
tb_clock_gen.sv
bus_interconnect_tb.sv

/* bus_interconnect_tb.sv */
module bus_interconnect_tb
	import bus_pkg::*, arb_pkg::*;
();
	timeunit 1ns;
	timeprecision 10ps;

	localparam int REGS = 16;
	localparam int ACK_TIMEOUT = 50;
	localparam int NUM_JOBS = 200;

	logic        sys_clk;
	logic        rst_n;
	logic        m1_req;
	logic        m1_we;
	bus_addr_t   m1_addr;
	bus_data_t   m1_wdata;
	logic        m1_ack;
	bus_data_t   m1_rdata;
	logic        m1_err;
	logic        m2_req;
	logic        m2_we;
	bus_addr_t   m2_addr;
	bus_data_t   m2_wdata;
	logic        m2_ack;
	bus_data_t   m2_rdata;
	logic        m2_err;

	bus_data_t   model [NUM_SLAVES][REGS];
	master_id_t  ack_order [$];
	logic [25:0] jobs [NUM_JOBS];   // {master, we, addr, wdata}
	logic [31:0] rand_state;
	int          errors;
	int          timeouts;

	tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) clk_gen_i (.sys_clk, .rst_n);

	bus_interconnect #(.REGS(REGS)) dut_i (
		.sys_clk, .rst_n,
		.m1_req, .m1_we, .m1_addr, .m1_wdata, .m1_ack, .m1_rdata, .m1_err,
		.m2_req, .m2_we, .m2_addr, .m2_wdata, .m2_ack, .m2_rdata, .m2_err
	);

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Slave select in bits 7:6, spare bits 5:4, register in 3:0
	function automatic bus_addr_t make_addr(input int slave, input int reg_i,
			input logic [1:0] spare);
		return {slave[1:0], spare, reg_i[3:0]};
	endfunction

	function automatic logic ack_of(input master_id_t m);
		return (m == MASTER_1) ? m1_ack : m2_ack;
	endfunction

	function automatic bus_data_t rdata_of(input master_id_t m);
		return (m == MASTER_1) ? m1_rdata : m2_rdata;
	endfunction

	function automatic logic err_of(input master_id_t m);
		return (m == MASTER_1) ? m1_err : m2_err;
	endfunction

	// Expected response and the bank update it implies
	function automatic void model_access(input logic we, input bus_addr_t addr,
			input bus_data_t wdata, output bus_data_t exp_rdata, output logic exp_err);
		int s;
		int r;
		s = addr[7:6];
		r = addr[3:0];
		exp_err = (s >= NUM_SLAVES) || (r >= REGS);
		exp_rdata = '0;
		if (!exp_err) begin
			exp_rdata = model[s][r];
			if (we)
				model[s][r] = wdata;
		end
	endfunction

	task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected 16'h%04h, got 16'h%04h",
				$time, name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_master(input string name, input master_id_t exp,
			input master_id_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %s, got %s",
				$time, name, exp.name(), act.name());
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic drive_master(input master_id_t m, input logic req, input logic we,
			input bus_addr_t addr, input bus_data_t wdata);
		if (m == MASTER_1) begin
			m1_req = req;
			m1_we = we;
			m1_addr = addr;
			m1_wdata = wdata;
		end else begin
			m2_req = req;
			m2_we = we;
			m2_addr = addr;
			m2_wdata = wdata;
		end
	endtask

	// Full four-phase transaction checked against the model at ack time
	task automatic handshake(input master_id_t m, input logic we, input bus_addr_t addr,
			input bus_data_t wdata, output bus_data_t rdata, output logic err,
			output int cycles);
		bus_data_t exp_rdata;
		logic      exp_err;
		string     tag;
		int        n;
		tag = (m == MASTER_1) ? "m1" : "m2";
		rdata = '0;
		err = 1'b0;
		cycles = 0;
		@(negedge sys_clk);
		drive_master(m, 1'b1, we, addr, wdata);
		while (cycles < ACK_TIMEOUT && !ack_of(m)) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (ack_of(m)) begin
			rdata = rdata_of(m);
			err = err_of(m);
			ack_order.push_back(m);
			model_access(we, addr, wdata, exp_rdata, exp_err);
			check_data({tag, "_rdata"}, exp_rdata, rdata);
			check_err({tag, "_err"}, exp_err, err);
		end else begin
			timeouts++;
			$display("Timeout at %0t ns: %s_ack did not rise within %0d cycles",
				$time, tag, ACK_TIMEOUT);
		end
		drive_master(m, 1'b0, we, addr, wdata);
		n = 0;
		while (n < ACK_TIMEOUT && ack_of(m)) begin
			@(negedge sys_clk);
			n++;
		end
		if (ack_of(m)) begin
			timeouts++;
			$display("Timeout at %0t ns: %s_ack stayed high after req dropped", $time, tag);
		end
	endtask

	task automatic wait_for_reset();
		int n;
		n = 0;
		while (n < 20 && rst_n !== 1'b1) begin
			@(posedge sys_clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("Timeout: reset was not released within 20 cycles");
		end
		@(negedge sys_clk);
	endtask

	task automatic test_m1_write_read();
		bus_data_t vals [NUM_SLAVES];
		bus_data_t rd;
		logic      e;
		int        c;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			vals[s] = 16'h1111 * 16'(s + 1);
			handshake(MASTER_1, 1'b1, make_addr(s, s + 2, 2'b00), vals[s], rd, e, c);
			check_data("m1_rdata", 16'h0000, rd);   // Old value is the reset value
			check_err("m1_err", 1'b0, e);
		end
		for (int s = 0; s < NUM_SLAVES; s++) begin
			handshake(MASTER_1, 1'b0, make_addr(s, s + 2, 2'b00), 16'h0000, rd, e, c);
			check_data("m1_rdata", vals[s], rd);
			check_err("m1_err", 1'b0, e);
		end
	endtask

	task automatic test_same_reg_per_slave();
		bus_data_t vals [NUM_SLAVES];
		bus_data_t rd;
		logic      e;
		int        c;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			vals[s] = 16'ha05a + 16'h0101 * 16'(s);
			handshake(MASTER_2, 1'b1, make_addr(s, 9, 2'b00), vals[s], rd, e, c);
		end
		for (int s = 0; s < NUM_SLAVES; s++) begin
			handshake(MASTER_1, 1'b0, make_addr(s, 9, 2'b00), 16'h0000, rd, e, c);
			check_data("m1_rdata", vals[s], rd);
		end
	endtask

	task automatic test_unmapped_slave();
		bus_data_t rd;
		logic      e;
		int        c;
		handshake(MASTER_1, 1'b1, make_addr(3, 4, 2'b00), 16'hdead, rd, e, c);
		check_err("m1_err", 1'b1, e);
		check_data("m1_rdata", 16'h0000, rd);
		handshake(MASTER_2, 1'b0, make_addr(3, 9, 2'b01), 16'h0000, rd, e, c);
		check_err("m2_err", 1'b1, e);
		// Spare address bits must not change the target register
		handshake(MASTER_2, 1'b1, make_addr(1, 12, 2'b11), 16'h5e5e, rd, e, c);
		handshake(MASTER_1, 1'b0, make_addr(1, 12, 2'b00), 16'h0000, rd, e, c);
		check_data("m1_rdata", 16'h5e5e, rd);
		handshake(MASTER_1, 1'b0, make_addr(1, 12, 2'b10), 16'h0000, rd, e, c);
		check_data("m1_rdata", 16'h5e5e, rd);
		for (int s = 0; s < NUM_SLAVES; s++) begin
			for (int r = 0; r < REGS; r++)
				handshake(MASTER_2, 1'b0, make_addr(s, r, 2'b00), 16'h0000, rd, e, c);
		end
	endtask

	task automatic test_contention();
		master_id_t last_exp;
		master_id_t first_exp;
		master_id_t second_exp;
		int         base;
		bus_data_t  rd1;
		bus_data_t  rd2;
		logic       e1;
		logic       e2;
		int         c1;
		int         c2;
		last_exp = MASTER_2;   // Master 1 wins the first tie after reset
		for (int rep = 0; rep < 3; rep++) begin
			// A tie goes to the master not granted last
			first_exp = (last_exp == MASTER_1) ? MASTER_2 : MASTER_1;
			second_exp = (first_exp == MASTER_1) ? MASTER_2 : MASTER_1;
			base = ack_order.size();
			fork
				handshake(MASTER_1, 1'b1, make_addr(rep, 5, 2'b00), 16'hc0de + 16'(rep),
					rd1, e1, c1);
				handshake(MASTER_2, 1'b0, make_addr(rep, 5, 2'b00), 16'h0000, rd2, e2, c2);
			join
			if (ack_order.size() != base + 2) begin
				errors++;
				$display("Contention round %0d did not complete both handshakes", rep);
			end else begin
				check_master("first ack", first_exp, ack_order[base]);
				check_master("second ack", second_exp, ack_order[base + 1]);
				check_cycles("m1 ack latency", (first_exp == MASTER_1) ? 3 : 4, c1);
				check_cycles("m2 ack latency", (first_exp == MASTER_2) ? 3 : 4, c2);
			end
			last_exp = second_exp;
		end
	endtask

	task automatic run_jobs(input master_id_t m);
		bus_data_t rd;
		logic      e;
		int        c;
		for (int i = 0; i < NUM_JOBS; i++) begin
			if (jobs[i][25] == m)
				handshake(m, jobs[i][24], jobs[i][23:16], jobs[i][15:0], rd, e, c);
		end
	endtask

	task automatic test_random_traffic();
		logic [31:0] r1;
		logic [31:0] r2;
		for (int i = 0; i < NUM_JOBS; i++) begin
			r1 = next_rand();
			r2 = next_rand();
			jobs[i] = {r1[31], r1[28], r1[23:16], r2[31:16]};
		end
		fork
			run_jobs(MASTER_1);
			run_jobs(MASTER_2);
		join
	endtask

	initial begin
		drive_master(MASTER_1, 1'b0, 1'b0, '0, '0);
		drive_master(MASTER_2, 1'b0, 1'b0, '0, '0);
		rand_state = 32'd52013;
		errors = 0;
		timeouts = 0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			for (int r = 0; r < REGS; r++)
				model[s][r] = '0;
		end
		wait_for_reset();
		test_contention();
		test_m1_write_read();
		test_same_reg_per_slave();
		test_unmapped_slave();
		test_random_traffic();
		$display("Checks done: %0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
	parameter real PERIOD_NS = 8.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic sys_clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 10ps;

	initial begin
		sys_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) sys_clk = ~sys_clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;   // Released away from the active edge
	end

endmodule

/* bus_interconnect.sv */
module bus_interconnect
	import bus_pkg::*, arb_pkg::*;
#(
	parameter int REGS = 16
) (
	input  logic      sys_clk,
	input  logic      rst_n,
	input  logic      m1_req,
	input  logic      m1_we,
	input  bus_addr_t m1_addr,
	input  bus_data_t m1_wdata,
	output logic      m1_ack,
	output bus_data_t m1_rdata,
	output logic      m1_err,
	input  logic      m2_req,
	input  logic      m2_we,
	input  bus_addr_t m2_addr,
	input  bus_data_t m2_wdata,
	output logic      m2_ack,
	output bus_data_t m2_rdata,
	output logic      m2_err
);

	// Arbiter to decoder
	logic       arb_valid;
	master_id_t arb_master;
	logic       arb_we;
	bus_addr_t  arb_addr;
	bus_data_t  arb_wdata;

	// Decoder to transfer
	logic       dec_valid;
	master_id_t dec_master;
	logic       dec_we;
	slave_idx_t dec_slave;
	reg_idx_t   dec_reg;
	logic       dec_err;
	bus_data_t  dec_wdata;

	logic [NUM_SLAVES-1:0] bank_we;
	reg_idx_t              bank_reg;
	bus_data_t             bank_wdata;
	bus_data_t             bank_rdata [NUM_SLAVES];

	bus_arbiter arb_i (
		.sys_clk, .rst_n,
		.m1_req, .m2_req, .m1_we, .m2_we,
		.m1_addr, .m2_addr, .m1_wdata, .m2_wdata,
		.arb_valid, .arb_master, .arb_we, .arb_addr, .arb_wdata
	);

	addr_decoder #(.REGS(REGS)) dec_i (
		.sys_clk, .rst_n,
		.arb_valid, .arb_master, .arb_we, .arb_addr, .arb_wdata,
		.dec_valid, .dec_master, .dec_we, .dec_slave, .dec_reg, .dec_err, .dec_wdata
	);

	bus_transfer xfer_i (
		.sys_clk, .rst_n,
		.dec_valid, .dec_master, .dec_we, .dec_slave, .dec_reg, .dec_err, .dec_wdata,
		.m1_req, .m2_req,
		.bank_rdata, .bank_we, .bank_reg, .bank_wdata,
		.m1_ack, .m2_ack, .m1_err, .m2_err, .m1_rdata, .m2_rdata
	);

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_bank
		slave_regbank #(.REGS(REGS)) bank_i (
			.sys_clk,
			.rst_n,
			.we      (bank_we[s]),
			.reg_idx (bank_reg),
			.wdata   (bank_wdata),
			.rdata   (bank_rdata[s])
		);
	end

endmodule

/* bus_transfer.sv */
module bus_transfer
	import bus_pkg::*, arb_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  rst_n,
	input  logic                  dec_valid,
	input  master_id_t            dec_master,
	input  logic                  dec_we,
	input  slave_idx_t            dec_slave,
	input  reg_idx_t              dec_reg,
	input  logic                  dec_err,
	input  bus_data_t             dec_wdata,
	input  logic                  m1_req,
	input  logic                  m2_req,
	input  bus_data_t             bank_rdata [NUM_SLAVES],
	output logic [NUM_SLAVES-1:0] bank_we,
	output reg_idx_t              bank_reg,
	output bus_data_t             bank_wdata,
	output logic                  m1_ack,
	output logic                  m2_ack,
	output logic                  m1_err,
	output logic                  m2_err,
	output bus_data_t             m1_rdata,
	output bus_data_t             m2_rdata
);

	logic [NUM_MASTERS-1:0] req_v;
	logic [NUM_MASTERS-1:0] ack_q;
	logic [NUM_MASTERS-1:0] err_q;
	bus_data_t              rdata_q [NUM_MASTERS];
	bus_data_t              rd_sel;

	assign req_v = {m2_req, m1_req};
	assign bank_reg = dec_reg;
	assign bank_wdata = dec_wdata;

	// Bank writes on the same edge that captures the old value
	always_comb begin
		bank_we = '0;
		rd_sel = '0;   // Error reads return zero
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (!dec_err && dec_slave == slave_idx_t'(s)) begin
				rd_sel = bank_rdata[s];
				bank_we[s] = dec_valid && dec_we;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= '0;
			err_q <= '0;
		end else begin
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (dec_valid && dec_master == master_id_t'(m)) begin
					ack_q[m] <= 1'b1;
					err_q[m] <= dec_err;
				end else if (!req_v[m]) begin
					ack_q[m] <= 1'b0;   // Four-phase return to idle
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (dec_valid)
			rdata_q[dec_master] <= rd_sel;
	end

	assign m1_ack = ack_q[MASTER_1];
	assign m2_ack = ack_q[MASTER_2];
	assign m1_err = err_q[MASTER_1];
	assign m2_err = err_q[MASTER_2];
	assign m1_rdata = rdata_q[MASTER_1];
	assign m2_rdata = rdata_q[MASTER_2];

	a_one_bank_we: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$onehot0(bank_we));

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_chk
		a_ack_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
			$rose(ack_q[m]) |-> $past(req_v[m]));
	end

endmodule

/* addr_decoder.sv */
module addr_decoder
	import bus_pkg::*, arb_pkg::*;
#(
	parameter int REGS = 16
) (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       arb_valid,
	input  master_id_t arb_master,
	input  logic       arb_we,
	input  bus_addr_t  arb_addr,
	input  bus_data_t  arb_wdata,
	output logic       dec_valid,
	output master_id_t dec_master,
	output logic       dec_we,
	output slave_idx_t dec_slave,
	output reg_idx_t   dec_reg,
	output logic       dec_err,
	output bus_data_t  dec_wdata
);

	slave_idx_t a_slave;
	reg_idx_t   a_reg;
	logic       a_err;

	assign a_slave = arb_addr[SLAVE_LSB +: SLAVE_W];
	assign a_reg = arb_addr[REG_LSB +: REG_W];

	// Unmapped slave or register past the end of the bank
	assign a_err = (a_slave >= NUM_SLAVES) || (int'(a_reg) >= REGS);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= arb_valid;
	end

	always_ff @(posedge sys_clk) begin
		if (arb_valid) begin
			dec_master <= arb_master;
			dec_we <= arb_we;
			dec_slave <= a_slave;
			dec_reg <= a_reg;
			dec_err <= a_err;
			dec_wdata <= arb_wdata;
		end
	end

endmodule

/* bus_arbiter.sv */
module bus_arbiter
	import arb_pkg::*, bus_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       m1_req,
	input  logic       m2_req,
	input  logic       m1_we,
	input  logic       m2_we,
	input  bus_addr_t  m1_addr,
	input  bus_addr_t  m2_addr,
	input  bus_data_t  m1_wdata,
	input  bus_data_t  m2_wdata,
	output logic       arb_valid,
	output master_id_t arb_master,
	output logic       arb_we,
	output bus_addr_t  arb_addr,
	output bus_data_t  arb_wdata
);

	logic [NUM_MASTERS-1:0] req_v;
	logic [NUM_MASTERS-1:0] served;   // Granted, waiting for req to drop
	logic [NUM_MASTERS-1:0] eligible;
	logic [NUM_MASTERS-1:0] granted;
	logic                   grant_any;
	master_id_t             winner;
	master_id_t             last_grant;

	assign req_v = {m2_req, m1_req};
	assign eligible = req_v & ~served;
	assign grant_any = |eligible;

	always_comb begin
		winner = MASTER_1;
		if (&eligible)
			winner = (last_grant == MASTER_1) ? MASTER_2 : MASTER_1;
		else if (eligible[MASTER_2])
			winner = MASTER_2;
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			arb_valid <= 1'b0;
			served <= '0;
			last_grant <= MASTER_2;   // So master 1 wins the first tie
		end else begin
			arb_valid <= grant_any;
			served <= served & req_v;
			if (grant_any) begin
				served[winner] <= 1'b1;
				last_grant <= winner;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (grant_any) begin
			arb_master <= winner;
			if (winner == MASTER_1) begin
				arb_we <= m1_we;
				arb_addr <= m1_addr;
				arb_wdata <= m1_wdata;
			end else begin
				arb_we <= m2_we;
				arb_addr <= m2_addr;
				arb_wdata <= m2_wdata;
			end
		end
	end

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_chk
		assign granted[m] = arb_valid && (arb_master == master_id_t'(m));

		a_grant_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
			granted[m] |-> $past(req_v[m]));

		// One grant per handshake until req drops
		a_one_grant: assert property (@(posedge sys_clk) disable iff (!rst_n)
			granted[m] |=> !granted[m] until !req_v[m]);
	end

endmodule

/* slave_regbank.sv */
module slave_regbank
	import bus_pkg::*;
#(
	parameter int REGS = 16
) (
	input  logic      sys_clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_idx_t  reg_idx,
	input  bus_data_t wdata,
	output bus_data_t rdata
);

	bus_data_t regs [REGS];
	logic      in_range;

	assign in_range = int'(reg_idx) < REGS;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < REGS; r++)
				regs[r] <= '0;
		end else if (we && in_range) begin
			regs[reg_idx] <= wdata;
		end
	end

	assign rdata = in_range ? regs[reg_idx] : '0;   // Old value during a write

endmodule

/* arb_pkg.sv */
package arb_pkg;

	localparam int NUM_MASTERS = 2;

	// Encoding doubles as the index into per-master vectors
	typedef enum logic [$clog2(NUM_MASTERS)-1:0] {
		MASTER_1,
		MASTER_2
	} master_id_t;

endpackage

/* bus_pkg.sv */
package bus_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;

	// Slave select 3 has no bank behind it
	localparam int NUM_SLAVES = 3;

	// Address fields, bits 5 and 4 are don't care
	localparam int SLAVE_LSB = 6;
	localparam int SLAVE_W = 2;
	localparam int REG_LSB = 0;
	localparam int REG_W = 4;

	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;
	typedef logic [SLAVE_W-1:0] slave_idx_t;
	typedef logic [REG_W-1:0] reg_idx_t;

endpackage
